/* logic/vmu_settings.svh */
// ##########################################################
// array size, data widths and cell address width
// for the 8 by 8 vector multiply unit
// ##########################################################

`ifndef VMU_SETTINGS_SVH
`define VMU_SETTINGS_SVH

// lanes per side of the array
`define VMU_N 8

// pixel and weight width
`define VMU_PIX_W 8

// product and accumulator width, sums wrap at this width
`define VMU_ACC_W 16

// one cell per (pixel, weight) pair
`define VMU_CELLS 64

// wishbone address of one cell
`define VMU_ADDR_W 6

`endif

/* logic/vmu_pkg.sv */
// ##########################################################
// shared types: bank select, sample row, product grid
// and the wishbone request and response
// ##########################################################

`default_nettype none

`include "vmu_settings.svh"

package vmu_pkg;

    typedef enum logic {
        bank_ping = 1'b0,
        bank_pong = 1'b1
    } bank_t;

    // one row of pixels and one row of weights, lane 0 in the low bits
    typedef struct packed {
        logic                                 valid;
        logic                                 clear;
        bank_t                                bank;
        logic [`VMU_N-1:0][`VMU_PIX_W-1:0]    pixel;
        logic [`VMU_N-1:0][`VMU_PIX_W-1:0]    weight;
    } sample_t;

    // cell j*8+i holds pixel i times weight j
    typedef struct packed {
        logic                                 valid;
        logic                                 clear;
        bank_t                                bank;
        logic [`VMU_CELLS-1:0][`VMU_ACC_W-1:0] products;
    } product_t;

    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [`VMU_ADDR_W-1:0] adr;
    } wb_req_t;

    typedef struct packed {
        logic                  ack;
        logic [`VMU_ACC_W-1:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

/* logic/prefix_adder16.sv */
// ##########################################################
// 16-bit brent-kung parallel prefix adder, no carry out
// ##########################################################

`default_nettype none

`include "vmu_settings.svh"

module prefix_adder16 (
    input  logic [`VMU_ACC_W-1:0] a,
    input  logic [`VMU_ACC_W-1:0] b,
    output logic [`VMU_ACC_W-1:0] sum
);

    localparam int w      = `VMU_ACC_W;
    localparam int levels = $clog2(w);

    // combine a high segment with the segment just below it, result is {g, p}
    function automatic logic [1:0] dot(
        input logic g_hi,
        input logic p_hi,
        input logic g_lo,
        input logic p_lo
    );
        return {g_hi | (p_hi & g_lo), p_hi & p_lo};
    endfunction

    // stage 0 is the bitwise generate and propagate
    logic [levels:0][w-1:0]   up_g;
    logic [levels:0][w-1:0]   up_p;

    // stage 0 of the down-sweep is the end of the up-sweep
    logic [levels-1:0][w-1:0] dn_g;
    logic [levels-1:0][w-1:0] dn_p;

    assign up_g[0] = a & b;
    assign up_p[0] = a ^ b;

    // up-sweep builds spans of 2, 4, 8 and 16 bits
    for (genvar l = 1; l <= levels; l++) begin : g_up
        for (genvar k = 0; k < w; k++) begin : g_bit
            if ((k + 1) % (1 << l) == 0) begin : g_dot
                assign {up_g[l][k], up_p[l][k]} = dot(
                    up_g[l-1][k],
                    up_p[l-1][k],
                    up_g[l-1][k - (1 << (l-1))],
                    up_p[l-1][k - (1 << (l-1))]
                );
            end else begin : g_pass
                assign up_g[l][k] = up_g[l-1][k];
                assign up_p[l][k] = up_p[l-1][k];
            end
        end
    end

    assign dn_g[0] = up_g[levels];
    assign dn_p[0] = up_p[levels];

    // down-sweep fills in the remaining prefixes, distance 4, 2 then 1
    for (genvar m = 1; m < levels; m++) begin : g_down
        localparam int s = 1 << (levels - 1 - m);
        for (genvar k = 0; k < w; k++) begin : g_bit
            if (((k + 1) % (2*s) == s) && (k >= 2*s)) begin : g_dot
                assign {dn_g[m][k], dn_p[m][k]} = dot(
                    dn_g[m-1][k],
                    dn_p[m-1][k],
                    dn_g[m-1][k - s],
                    dn_p[m-1][k - s]
                );
            end else begin : g_pass
                assign dn_g[m][k] = dn_g[m-1][k];
                assign dn_p[m][k] = dn_p[m-1][k];
            end
        end
    end

    // dn_g of the last stage is the carry out of bits 0..k
    // no carry in, so bit 0 is just the propagate
    assign sum = up_p[0] ^ {dn_g[levels-1][w-2:0], 1'b0};

endmodule

`default_nettype wire

/* logic/product_array.sv */
// ##########################################################
// registered 8 by 8 multiplier grid with control pipeline
// ##########################################################

`default_nettype none

`include "vmu_settings.svh"

module product_array
    import vmu_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  sample_t  sample,
    output product_t prod
);

    // unsigned 8x8 multiply widened to the accumulator width
    function automatic logic [`VMU_ACC_W-1:0] mul_cell(
        input logic [`VMU_PIX_W-1:0] pix,
        input logic [`VMU_PIX_W-1:0] wgt
    );
        logic [`VMU_ACC_W-1:0] pix_ext;
        logic [`VMU_ACC_W-1:0] wgt_ext;
        pix_ext = {{(`VMU_ACC_W - `VMU_PIX_W){1'b0}}, pix};
        wgt_ext = {{(`VMU_ACC_W - `VMU_PIX_W){1'b0}}, wgt};
        return pix_ext * wgt_ext;
    endfunction

    always_ff @(posedge clk) begin
        // flags ride along with the products they belong to
        prod.clear <= sample.clear;
        prod.bank  <= sample.bank;

        // weight j selects the row of cells, pixel i the column
        for (int j = 0; j < `VMU_N; j++) begin
            for (int i = 0; i < `VMU_N; i++) begin
                prod.products[j*`VMU_N + i] <= mul_cell(sample.pixel[i], sample.weight[j]);
            end
        end

        if (reset) begin
            prod.valid <= 1'b0;
        end else begin
            prod.valid <= sample.valid;
        end
    end

endmodule

`default_nettype wire

/* logic/accum_bank.sv */
// ##########################################################
// one bank of 64 wrapping accumulators, ping or pong
// ##########################################################

`default_nettype none

`include "vmu_settings.svh"

module accum_bank
    import vmu_pkg::*;
#(
    parameter bank_t bank_id = bank_ping
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  product_t                              prod,
    output logic [`VMU_CELLS-1:0][`VMU_ACC_W-1:0] bank_sums
);

    logic [`VMU_CELLS-1:0][`VMU_ACC_W-1:0] next_sums;
    logic                                  active;

    // this bank takes the product only when it is the one selected
    assign active = prod.valid && (prod.bank == bank_id);

    for (genvar c = 0; c < `VMU_CELLS; c++) begin : g_cell
        prefix_adder16 adder (
            .a   (bank_sums[c]),
            .b   (prod.products[c]),
            .sum (next_sums[c])
        );

        // prefix tree must agree with a plain wrapping add
        adder_matches_add: assert property (
            @(posedge clk) disable iff (reset)
            next_sums[c] == bank_sums[c] + prod.products[c]
        );
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bank_sums <= '0;
        end else if (active) begin
            for (int c = 0; c < `VMU_CELLS; c++) begin
                // clear restarts the cell at this product
                if (prod.clear) begin
                    bank_sums[c] <= prod.products[c];
                end else begin
                    bank_sums[c] <= next_sums[c];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/result_reader.sv */
// ##########################################################
// wishbone classic read port over the idle bank
// ##########################################################

`default_nettype none

`include "vmu_settings.svh"

module result_reader
    import vmu_pkg::*;
(
    input  logic                                  clk,
    input  logic                                  reset,
    input  bank_t                                 bank,
    input  logic [`VMU_CELLS-1:0][`VMU_ACC_W-1:0] ping_sums,
    input  logic [`VMU_CELLS-1:0][`VMU_ACC_W-1:0] pong_sums,
    input  wb_req_t                               wb_req,
    output wb_rsp_t                               wb_rsp
);

    logic [`VMU_ACC_W-1:0] idle_cell;
    logic                  request;

    // read side is always the bank that is not accumulating
    always_comb begin
        if (bank == bank_ping) begin
            idle_cell = pong_sums[wb_req.adr];
        end else begin
            idle_cell = ping_sums[wb_req.adr];
        end
    end

    // a new request is one not already being acked
    assign request = wb_req.cyc && wb_req.stb && !wb_rsp.ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_rsp.ack <= 1'b0;
        end else begin
            wb_rsp.ack <= request;
        end

        // writes have no target and read back zero
        if (request) begin
            wb_rsp.dat <= wb_req.we ? '0 : idle_cell;
        end
    end

    // the bank under a read must not take a late product in the next cycle
    idle_bank_settled: assert property (
        @(posedge clk) disable iff (reset)
        request |=> (($past(bank) == bank_ping) ? $stable(pong_sums) : $stable(ping_sums))
    );

endmodule

`default_nettype wire

/* logic/vmu_array.sv */
// ##########################################################
// vector multiply unit top: multiplier grid, ping and
// pong banks, wishbone result reader
// ##########################################################

`default_nettype none

`include "vmu_settings.svh"

module vmu_array
    import vmu_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  sample_t sample,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp
);

    product_t                              prod;
    logic [`VMU_CELLS-1:0][`VMU_ACC_W-1:0] ping_sums;
    logic [`VMU_CELLS-1:0][`VMU_ACC_W-1:0] pong_sums;

    product_array products (
        .clk    (clk),
        .reset  (reset),
        .sample (sample),
        .prod   (prod)
    );

    // both banks see every product and pick by prod.bank
    accum_bank #(
        .bank_id (bank_ping)
    ) ping_bank (
        .clk       (clk),
        .reset     (reset),
        .prod      (prod),
        .bank_sums (ping_sums)
    );

    accum_bank #(
        .bank_id (bank_pong)
    ) pong_bank (
        .clk       (clk),
        .reset     (reset),
        .prod      (prod),
        .bank_sums (pong_sums)
    );

    // idle bank follows the live bank select
    result_reader reader (
        .clk       (clk),
        .reset     (reset),
        .bank      (sample.bank),
        .ping_sums (ping_sums),
        .pong_sums (pong_sums),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp)
    );

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
// ##########################################################
// testbench clock, period 20, and a 3 cycle reset
// ##########################################################

`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

/* testbench/vmu_array_tb.sv */
// ##########################################################
// testbench for the vector multiply unit: data file driven
// samples and wishbone reads, checks and watchdog
// ##########################################################

`default_nettype none

`include "vmu_settings.svh"

module vmu_array_tb
    import vmu_pkg::*;
();

    localparam int ack_limit = 8;

    logic    clk;
    logic    reset;
    sample_t sample;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;

    int      errors;
    int      checks;
    int      seed;
    string   script[$];
    bit      lines_loaded;

    tb_clock clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    vmu_array dut0 (
        .clk    (clk),
        .reset  (reset),
        .sample (sample),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    task automatic send_sample(input logic clear, input bank_t bank,
                               input logic [63:0] pix, input logic [63:0] wgt);
        @(posedge clk);
        sample.valid  <= 1'b1;
        sample.clear  <= clear;
        sample.bank   <= bank;
        sample.pixel  <= pix;
        sample.weight <= wgt;
    endtask

    // only valid drops and the bank select stays
    task automatic idle_cycles(input int count);
        repeat (count) begin
            @(posedge clk);
            sample.valid <= 1'b0;
        end
    endtask

    task automatic read_cell(input int adr, input logic [31:0] expected);
        int waited;
        waited = 0;
        @(posedge clk);
        sample.valid <= 1'b0;
        wb_req.cyc   <= 1'b1;
        wb_req.stb   <= 1'b1;
        wb_req.we    <= 1'b0;
        wb_req.adr   <= adr[`VMU_ADDR_W-1:0];
        @(negedge clk);
        while (!wb_rsp.ack && waited < ack_limit) begin
            @(negedge clk);
            waited++;
        end
        if (!wb_rsp.ack) begin
            errors++;
            $display("read of cell %0d got no ack by time %0t", adr, $time);
        end else begin
            check_value("ack delay in cycles", waited, 1);
            check_value("wb_rsp.dat", wb_rsp.dat, expected);
        end
        // master drops the request in the ack cycle
        @(posedge clk);
        wb_req.cyc <= 1'b0;
        wb_req.stb <= 1'b0;
        @(negedge clk);
        check_value("wb_rsp.ack", wb_rsp.ack, 0);
    endtask

    task automatic report_bad_line(input string text);
        errors++;
        $display("data file line could not be read: %s", text);
    endtask

    task automatic run_line(input string text);
        int          clear_v;
        int          bank_v;
        int          adr;
        int          count;
        int          idle;
        int          fields;
        logic [63:0] pix;
        logic [63:0] wgt;
        logic [31:0] expected;
        logic [7:0]  kind;
        kind = text.getc(0);
        case (kind)
            "S": begin
                fields = $sscanf(text, "S %d %d %h %h", clear_v, bank_v, pix, wgt);
                if (fields != 4) begin
                    report_bad_line(text);
                end else begin
                    send_sample(clear_v[0], bank_t'(bank_v[0]), pix, wgt);
                    // 0 to 2 idle cycles between samples
                    idle = $unsigned($random(seed)) % 3;
                    idle_cycles(idle);
                end
            end
            "R": begin
                fields = $sscanf(text, "R %d %h", adr, expected);
                if (fields != 2) begin
                    report_bad_line(text);
                end else begin
                    read_cell(adr, expected);
                end
            end
            "W": begin
                fields = $sscanf(text, "W %d", count);
                if (fields != 1) begin
                    report_bad_line(text);
                end else begin
                    idle_cycles(count);
                end
            end
            default: begin
                // comment or blank line
            end
        endcase
    endtask

    initial begin
        string line;
        int    fd;
        sample = '0;
        wb_req = '0;
        errors = 0;
        checks = 0;
        seed   = 32'h9b1e;
        fd = $fopen("testbench/vmu_testdata.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open testbench/vmu_testdata.txt");
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) > 0) begin
                    script.push_back(line);
                end
            end
            $fclose(fd);
        end
        lines_loaded = 1'b1;
        // wait for the reset pulse to pass
        wait (reset === 1'b1);
        wait (reset === 1'b0);
        foreach (script[n]) begin
            run_line(script[n]);
        end
        repeat (2) @(posedge clk);
        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // 40 cycles per data file line plus room for reset
    initial begin
        wait (lines_loaded);
        repeat (40 * script.size() + 20) @(posedge clk);
        $display("watchdog: run did not end within %0d cycles", 40 * script.size() + 20);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/vmu_testdata.txt */
# S clear bank pixel_row weight_row  (hex rows, lane 0 in the low byte, bank 0 ping 1 pong)
# R cell expected_hex (reads the idle bank)   W idle_cycles
# after reset, pong is idle first
R 0 0000
R 63 0000
S 1 1 0000000000000000 0000000000000000
W 2
R 0 0000
R 63 0000
# one cleared sample into ping, cell j*8+i holds (i+1)*(j+2)
S 1 0 0807060504030201 0908070605040302
S 1 1 0000000000000000 0000000000000000
W 2
R 0 0002
R 7 0010
R 9 0006
R 42 0015
R 56 0009
R 63 0048
# accumulate into ping, wraps past 2^16 twice
S 1 0 ffffffffffffffff ffffffffffffffff
S 0 0 ffffffffffffffff ffffffffffffffff
W 3
S 0 0 0807060504030201 0908070605040302
S 0 0 8080808080808080 c0c0c0c0c0c0c0c0
W 5
# pong stays at zero while ping works
R 0 0000
S 1 1 0000000000000000 0000000000000000
W 2
R 0 5c04
R 42 5c17
R 63 5c4a
# pong accumulates 3*(8-i) while ping is read
S 0 1 0102030405060708 0101010101010101
R 0 5c04
S 0 1 0102030405060708 0202020202020202
R 63 5c4a
W 3
R 42 5c17
S 0 0 0000000000000000 0000000000000000
W 2
R 0 0018
R 7 0003
R 10 0012
R 63 0003
# clear restarts ping at the new product
S 1 0 0000000000000003 0000000000000005
S 0 0 0000000000000003 0000000000000005
S 0 1 0000000000000000 0000000000000000
W 2
R 0 001e
R 1 0000
R 8 0000
R 63 0000

/* all.f */
+incdir+logic
logic/vmu_pkg.sv
logic/prefix_adder16.sv
logic/product_array.sv
logic/accum_bank.sv
logic/result_reader.sv
logic/vmu_array.sv
testbench/tb_clock.sv
testbench/vmu_array_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the vector multiply unit testbench with verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f all.f \
    --top-module vmu_array_tb \
    -Mdir obj_dir \
    -o vmu_sim

# the log decides the result, not the exit status of the run
./obj_dir/vmu_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "all tests passed" sim.log; then
    echo "simulation result: pass"
    exit 0
else
    echo "simulation result: fail"
    exit 1
fi
